//--- dv/noc_tb.sv
// Testbench for the four-node network, two APB ports sharing one memory
// A reference array tracks every write; concurrent assertions compare each response
// Transfers are driven 1 ns after the clock edge and start one edge after another ends

`timescale 1ns/1ps

module noc_tb;

  import noc_pkg::*;

  localparam int Timeout  = 200;               // Cycles allowed per APB transfer
  localparam int WordBits = $clog2(MemWords);
  localparam int Rounds   = 200;

  logic                  clk, reset;
  logic                  psel_a, penable_a, pwrite_a;
  logic                  psel_b, penable_b, pwrite_b;
  logic [PaddrWidth-1:0] paddr_a, paddr_b;
  logic [DataWidth-1:0]  pwdata_a, pwdata_b;
  logic [DataWidth-1:0]  prdata_a, prdata_b;
  logic                  pready_a, pready_b, pslverr_a, pslverr_b;

  // Expected response of the transfer in flight on each port
  logic [DataWidth-1:0]  exp_rdata_a, exp_rdata_b;
  logic                  exp_err_a, exp_err_b;
  logic [DataWidth-1:0]  ref_mem [MemWords];

  noc_top noc_top_i (
    .clk_i      (clk),       .reset_i    (reset),
    .psel_a_i   (psel_a),    .penable_a_i(penable_a), .pwrite_a_i (pwrite_a),
    .paddr_a_i  (paddr_a),   .pwdata_a_i (pwdata_a),  .prdata_a_o (prdata_a),
    .pready_a_o (pready_a),  .pslverr_a_o(pslverr_a),
    .psel_b_i   (psel_b),    .penable_b_i(penable_b), .pwrite_b_i (pwrite_b),
    .paddr_b_i  (paddr_b),   .pwdata_b_i (pwdata_b),  .prdata_b_o (prdata_b),
    .pready_b_o (pready_b),  .pslverr_b_o(pslverr_b)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  function automatic logic in_range(logic [MemIdxWidth-1:0] idx);
    return idx < MemIdxWidth'(MemWords);
  endfunction

  // Writes and errors answer with zero data
  function automatic logic [DataWidth-1:0] expected_rdata(logic wr,
                                                          logic [MemIdxWidth-1:0] idx);
    if (wr || !in_range(idx)) return '0;
    return ref_mem[idx[WordBits-1:0]];
  endfunction

  ////////////////////////////////////////////////////////////////////
  // APB transfers, called 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////

  task automatic port_a_transfer(input logic wr, input logic [MemIdxWidth-1:0] idx,
                                 input logic [DataWidth-1:0] wdata);
    int cycles;
    exp_rdata_a = expected_rdata(wr, idx);
    exp_err_a   = !in_range(idx);
    psel_a      = 1'b1;  // Setup phase
    pwrite_a    = wr;
    paddr_a     = {idx, 2'b00};
    pwdata_a    = wdata;
    @(posedge clk);
    #1;
    penable_a = 1'b1;
    cycles    = 0;
    while (!pready_a && cycles < Timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!pready_a) begin
      $display("Port A hung: no pready within %0d cycles", Timeout);
      $display("Checks failed");
      $fatal(1);
    end else begin
      @(posedge clk);  // Completion edge
      #1;
      psel_a    = 1'b0;
      penable_a = 1'b0;
      if (wr && in_range(idx)) ref_mem[idx[WordBits-1:0]] = wdata;
    end
  endtask

  task automatic port_b_transfer(input logic wr, input logic [MemIdxWidth-1:0] idx,
                                 input logic [DataWidth-1:0] wdata);
    int cycles;
    exp_rdata_b = expected_rdata(wr, idx);
    exp_err_b   = !in_range(idx);
    psel_b      = 1'b1;
    pwrite_b    = wr;
    paddr_b     = {idx, 2'b00};
    pwdata_b    = wdata;
    @(posedge clk);
    #1;
    penable_b = 1'b1;
    cycles    = 0;
    while (!pready_b && cycles < Timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!pready_b) begin
      $display("Port B hung: no pready within %0d cycles", Timeout);
      $display("Checks failed");
      $fatal(1);
    end else begin
      @(posedge clk);
      #1;
      psel_b    = 1'b0;
      penable_b = 1'b0;
      if (wr && in_range(idx)) ref_mem[idx[WordBits-1:0]] = wdata;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////

  a_rsp_a: assert property (@(posedge clk) disable iff (reset)
    pready_a |-> prdata_a == exp_rdata_a && pslverr_a == exp_err_a)
    else begin
      $display("[ERROR] %0t port A response %h err %b, expected %h err %b", $time,
               $sampled(prdata_a), $sampled(pslverr_a), exp_rdata_a, exp_err_a);
      $display("Checks failed");
      $fatal(1);
    end

  a_rsp_b: assert property (@(posedge clk) disable iff (reset)
    pready_b |-> prdata_b == exp_rdata_b && pslverr_b == exp_err_b)
    else begin
      $display("[ERROR] %0t port B response %h err %b, expected %h err %b", $time,
               $sampled(prdata_b), $sampled(pslverr_b), exp_rdata_b, exp_err_b);
      $display("Checks failed");
      $fatal(1);
    end

  // pready may only answer an access phase
  a_access_a: assert property (@(posedge clk) disable iff (reset)
    pready_a |-> psel_a && penable_a)
    else begin
      $display("[ERROR] %0t port A pready outside an access phase", $time);
      $display("Checks failed");
      $fatal(1);
    end

  a_access_b: assert property (@(posedge clk) disable iff (reset)
    pready_b |-> psel_b && penable_b)
    else begin
      $display("[ERROR] %0t port B pready outside an access phase", $time);
      $display("Checks failed");
      $fatal(1);
    end

  a_reset_quiet: assert property (@(posedge clk) reset |=> !pready_a && !pready_b)
    else begin
      $display("[ERROR] %0t pready high in the cycle after reset", $time);
      $display("Checks failed");
      $fatal(1);
    end

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic [MemIdxWidth-1:0] idx_a, idx_b;
    logic                   wr_a, wr_b;
    logic [DataWidth-1:0]   data_a, data_b;
    void'($urandom(86));
    clk       = 1'b0;
    reset     = 1'b1;
    psel_a    = 1'b0;
    penable_a = 1'b0;
    pwrite_a  = 1'b0;
    paddr_a   = '0;
    pwdata_a  = '0;
    psel_b    = 1'b0;
    penable_b = 1'b0;
    pwrite_b  = 1'b0;
    paddr_b   = '0;
    pwdata_b  = '0;
    exp_rdata_a = '0;
    exp_rdata_b = '0;
    exp_err_a   = 1'b0;
    exp_err_b   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (4) @(posedge clk);  // Idle ports, pready must stay low
    #1;

    // Fill every word so later reads have known data
    for (int i = 0; i < MemWords; i++) begin
      if (i % 2 == 0) port_a_transfer(1'b1, MemIdxWidth'(i), $urandom);
      else            port_b_transfer(1'b1, MemIdxWidth'(i), $urandom);
    end

    // Write then read on port A
    port_a_transfer(1'b1, 10'd17, $urandom);
    port_a_transfer(1'b0, 10'd17, '0);

    // Across ports, both directions
    port_b_transfer(1'b1, 10'd40, $urandom);
    port_a_transfer(1'b0, 10'd40, '0);
    port_a_transfer(1'b1, 10'd41, $urandom);
    port_b_transfer(1'b0, 10'd41, '0);

    // Out of range, index 261 would alias word 5 if decoded short
    port_a_transfer(1'b1, 10'd261, $urandom);
    port_b_transfer(1'b0, 10'd1023, '0);
    port_b_transfer(1'b1, 10'd300, $urandom);
    for (int i = 0; i < MemWords; i++) port_a_transfer(1'b0, MemIdxWidth'(i), '0);

    // Both ports at once, distinct words
    for (int r = 0; r < Rounds; r++) begin
      idx_a  = MemIdxWidth'($urandom_range(MemWords - 1));
      idx_b  = MemIdxWidth'((int'(idx_a) + 1 + $urandom_range(MemWords - 2)) % MemWords);
      wr_a   = ($urandom_range(1) == 1);
      wr_b   = ($urandom_range(1) == 1);
      data_a = $urandom;
      data_b = $urandom;
      fork
        port_a_transfer(wr_a, idx_a, data_a);
        port_b_transfer(wr_b, idx_b, data_b);
      join
    end

    for (int i = 0; i < MemWords; i++) port_b_transfer(1'b0, MemIdxWidth'(i), '0);

    $display("All checks passed");
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the network testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module noc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vnoc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi

//--- source/apb_chimney.sv
// APB completer that turns each transfer into one request flit to NodeMem
// Only one transfer is outstanding; pready follows the response by one cycle
// paddr bits 1:0 are ignored, all accesses are full words

`timescale 1ns/1ps

module apb_chimney (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  noc_pkg::node_id_t                node_id_i,
  // APB
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [noc_pkg::PaddrWidth-1:0]   paddr_i,
  input  logic [noc_pkg::DataWidth-1:0]    pwdata_i,
  output logic [noc_pkg::DataWidth-1:0]    prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  // Request to the router
  output noc_pkg::flit_t                   req_flit_o,
  output logic                             req_valid_o,
  input  logic                             req_ready_i,
  // Response from the router
  input  noc_pkg::flit_t                   rsp_flit_i,
  input  logic                             rsp_valid_i,
  output logic                             rsp_ready_o
);

  import noc_pkg::*;

  enum logic [1:0] {StIdle, StSend, StWait} state_q, state_d;

  logic                 pready_q, pslverr_q;
  logic [DataWidth-1:0] prdata_q;
  logic                 access, rsp_fire;

  // First access-phase cycle, not the completion cycle
  assign access = psel_i && penable_i && !pready_q;

  // APB holds address and data until pready, so the flit stays stable
  always_comb begin
    req_flit_o                     = '0;
    req_flit_o.kind                = FlitReq;
    req_flit_o.src                 = node_id_i;
    req_flit_o.dst                 = NodeMem;
    req_flit_o.payload.req.write   = pwrite_i;
    req_flit_o.payload.req.idx     = paddr_i[PaddrWidth-1:2];
    req_flit_o.payload.req.wdata   = pwdata_i;
  end

  always_comb begin
    state_d     = state_q;
    req_valid_o = 1'b0;
    unique case (state_q)
      StIdle: begin
        if (access) begin
          req_valid_o = 1'b1;  // Offered in the same cycle
          state_d     = req_ready_i ? StWait : StSend;
        end
      end
      StSend: begin
        req_valid_o = 1'b1;
        if (req_ready_i) state_d = StWait;
      end
      StWait: begin
        if (rsp_valid_i) state_d = StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  assign rsp_ready_o = (state_q == StWait);
  assign rsp_fire    = rsp_valid_i && rsp_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= StIdle;
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      pready_q <= rsp_fire;  // Single-cycle pulse
      if (rsp_fire) pslverr_q <= rsp_flit_i.payload.rsp.err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_fire) prdata_q <= rsp_flit_i.payload.rsp.rdata;
  end

  assign prdata_o  = prdata_q;
  assign pready_o  = pready_q;
  assign pslverr_o = pslverr_q;

  a_pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
    pready_o |-> psel_i && penable_i)
    else $error("chimney %0d: pready outside an access phase", node_id_i);

  // Routing must deliver only our own responses here
  a_rsp_is_ours: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_fire |-> rsp_flit_i.kind == FlitRsp && rsp_flit_i.dst == node_id_i)
    else $error("chimney %0d: foreign flit accepted", node_id_i);

endmodule

//--- source/mem_endpoint.sv
// Word memory behind the network, one request at a time
// Out-of-range index answers with err set and zero data, memory untouched
// No reset on the array, contents are unknown until written

`timescale 1ns/1ps

module mem_endpoint (
  input  logic           clk_i,
  input  logic           reset_i,
  input  noc_pkg::flit_t req_flit_i,
  input  logic           req_valid_i,
  output logic           req_ready_o,
  output noc_pkg::flit_t rsp_flit_o,
  output logic           rsp_valid_o,
  input  logic           rsp_ready_i
);

  import noc_pkg::*;

  logic [DataWidth-1:0] mem_q [MemWords];
  flit_t                rsp_q;
  logic                 rsp_valid_q, live_q;
  req_payload_t         req;
  logic                 accept, in_range;
  logic [DataWidth-1:0] rd_word;

  assign req         = req_flit_i.payload.req;
  assign in_range    = req.idx < MemIdxWidth'(MemWords);
  assign req_ready_o = live_q && !rsp_valid_q;  // Free response slot
  assign accept      = req_valid_i && req_ready_o;
  assign rd_word     = mem_q[req.idx[$clog2(MemWords)-1:0]];

  always_ff @(posedge clk_i) begin
    if (accept && in_range && req.write) begin
      mem_q[req.idx[$clog2(MemWords)-1:0]] <= req.wdata;
    end
  end

  // Response goes back to whoever asked
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q                     <= '0;
      rsp_q.kind                <= FlitRsp;
      rsp_q.src                 <= NodeMem;
      rsp_q.dst                 <= req_flit_i.src;
      rsp_q.payload.rsp.err     <= !in_range;
      rsp_q.payload.rsp.rdata   <= (in_range && !req.write) ? rd_word : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      live_q      <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (accept)           rsp_valid_q <= 1'b1;
      else if (rsp_ready_i) rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_flit_o  = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  a_req_only: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> req_flit_i.kind == FlitReq)
    else $error("mem endpoint accepted a response flit");

endmodule

//--- source/noc_pkg.sv
// Shared definitions for the four-node, single-row network
// Node ids double as the column position, so routing is a plain compare
// FifoDepth must be a power of two since FIFO pointers wrap naturally

package noc_pkg;

  ////////////////////////////////////////////////////////////////////
  // Nodes and sizes
  ////////////////////////////////////////////////////////////////////

  typedef logic [1:0] node_id_t;

  localparam node_id_t NodeChimA = 2'd0;  // APB port A
  localparam node_id_t NodeRelay = 2'd1;  // Forwarding only
  localparam node_id_t NodeMem   = 2'd2;  // Shared memory
  localparam node_id_t NodeChimB = 2'd3;  // APB port B

  localparam int DataWidth   = 32;
  localparam int PaddrWidth  = 12;
  localparam int MemIdxWidth = 10;
  localparam int MemWords    = 256;  // Index at or above this is an error
  localparam int FifoDepth   = 2;
  localparam int NumPorts    = 3;    // West, East, Local

  // Router port index
  typedef enum logic [1:0] {
    West  = 2'd0,
    East  = 2'd1,
    Local = 2'd2
  } port_e;

  typedef enum logic {
    FlitReq = 1'b0,
    FlitRsp = 1'b1
  } flit_kind_e;

  ////////////////////////////////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   write;
    logic [MemIdxWidth-1:0] idx;    // Word index, not byte address
    logic [DataWidth-1:0]   wdata;
  } req_payload_t;

  typedef struct packed {
    logic                   err;
    logic [DataWidth-1:0]   rdata;
    logic [MemIdxWidth-1:0] pad;    // Keeps both views at 43 bits
  } rsp_payload_t;

  // Same 43 bits, read by the kind field
  typedef union packed {
    req_payload_t req;
    rsp_payload_t rsp;
  } payload_u;

  typedef struct packed {
    flit_kind_e kind;
    node_id_t   src;
    node_id_t   dst;
    payload_u   payload;
  } flit_t;

endpackage

//--- source/noc_router.sv
// Three-port router (West, East, Local) for a single row of nodes
// Routing compares the destination id with node_id_i, so ids must grow eastwards
// Output valid and flit are combinational from the FIFO heads, ready_o is registered

`timescale 1ns/1ps

module noc_router (
  input  logic              clk_i,
  input  logic              reset_i,
  input  noc_pkg::node_id_t node_id_i,
  // West link
  input  noc_pkg::flit_t    west_flit_i,
  input  logic              west_valid_i,
  output logic              west_ready_o,
  output noc_pkg::flit_t    west_flit_o,
  output logic              west_valid_o,
  input  logic              west_ready_i,
  // East link
  input  noc_pkg::flit_t    east_flit_i,
  input  logic              east_valid_i,
  output logic              east_ready_o,
  output noc_pkg::flit_t    east_flit_o,
  output logic              east_valid_o,
  input  logic              east_ready_i,
  // Local link
  input  noc_pkg::flit_t    local_flit_i,
  input  logic              local_valid_i,
  output logic              local_ready_o,
  output noc_pkg::flit_t    local_flit_o,
  output logic              local_valid_o,
  input  logic              local_ready_i
);

  import noc_pkg::*;

  flit_t               in_flit   [NumPorts];
  flit_t               head_flit [NumPorts];
  flit_t               out_flit  [NumPorts];
  port_e               head_port [NumPorts];
  port_e               out_gnt   [NumPorts];
  logic [NumPorts-1:0] in_valid, in_ready, head_valid, pop;
  logic [NumPorts-1:0] out_valid, out_ready;
  logic                live_q;  // Holds all ready outputs low for the first cycle

  function automatic port_e route(node_id_t dst, node_id_t id);
    if (dst < id) return West;
    if (dst > id) return East;
    return Local;
  endfunction

  function automatic port_e next_port(port_e p);
    return (p == Local) ? West : port_e'(p + 2'd1);
  endfunction

  // Gather the loose ports into arrays by port index
  assign in_flit[West]   = west_flit_i;
  assign in_flit[East]   = east_flit_i;
  assign in_flit[Local]  = local_flit_i;
  assign in_valid        = {local_valid_i, east_valid_i, west_valid_i};
  assign out_ready       = {local_ready_i, east_ready_i, west_ready_i};
  assign west_ready_o    = in_ready[West];
  assign east_ready_o    = in_ready[East];
  assign local_ready_o   = in_ready[Local];
  assign west_flit_o     = out_flit[West];
  assign east_flit_o     = out_flit[East];
  assign local_flit_o    = out_flit[Local];
  assign west_valid_o    = out_valid[West];
  assign east_valid_o    = out_valid[East];
  assign local_valid_o   = out_valid[Local];

  always_ff @(posedge clk_i) begin
    if (reset_i) live_q <= 1'b0;
    else         live_q <= 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Input FIFOs
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : g_in
    flit_t                          mem_q [FifoDepth];  // Payload only, no reset
    logic [$clog2(FifoDepth)-1:0]   wr_ptr_q, rd_ptr_q;
    logic [$clog2(FifoDepth+1)-1:0] cnt_q;
    logic                           push;

    assign in_ready[p]   = live_q && (cnt_q != FifoDepth);
    assign push          = in_valid[p] && in_ready[p];
    assign head_valid[p] = (cnt_q != '0);
    assign head_flit[p]  = mem_q[rd_ptr_q];
    assign head_port[p]  = route(mem_q[rd_ptr_q].dst, node_id_i);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push)   wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop[p]) rd_ptr_q <= rd_ptr_q + 1'b1;
        if (push && !pop[p])      cnt_q <= cnt_q + 1'b1;
        else if (!push && pop[p]) cnt_q <= cnt_q - 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) mem_q[wr_ptr_q] <= in_flit[p];
    end

    // A write into a full FIFO lands on the unread head slot
    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
      head_valid[p] && !pop[p] |=> head_valid[p] && $stable(head_flit[p]))
      else $error("router %0d: input FIFO %0d written while full", node_id_i, p);
  end

  //////////////////////////////////////////////////////////////////////
  // Output arbiters
  //////////////////////////////////////////////////////////////////////

  for (genvar o = 0; o < NumPorts; o++) begin : g_out
    logic [NumPorts-1:0] req;
    port_e               prio_q;      // Input with top priority
    port_e               lock_gnt_q;
    port_e               gnt;
    logic                lock_q;      // Output stalled last cycle

    // Never send a flit back where it came from
    always_comb begin
      for (int i = 0; i < NumPorts; i++) begin
        req[i] = head_valid[i] && (i != o) && (head_port[i] == port_e'(o));
      end
    end

    always_comb begin
      int idx;
      idx = 0;
      gnt = prio_q;
      // Walk backwards so the input nearest to prio_q wins
      for (int k = NumPorts - 1; k >= 0; k--) begin
        idx = (int'(prio_q) + k) % NumPorts;
        if (req[idx]) gnt = port_e'(idx);
      end
      if (lock_q) gnt = lock_gnt_q;  // Stalled flit keeps the output
    end

    assign out_valid[o] = |req;
    assign out_flit[o]  = head_flit[gnt];
    assign out_gnt[o]   = gnt;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        prio_q     <= West;
        lock_gnt_q <= West;
        lock_q     <= 1'b0;
      end else begin
        lock_q     <= out_valid[o] && !out_ready[o];
        lock_gnt_q <= gnt;
        if (out_valid[o] && out_ready[o]) prio_q <= next_port(gnt);
      end
    end

    a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_flit[o]))
      else $error("router %0d: output %0d changed while stalled", node_id_i, o);
  end

  // Each head routes to exactly one output, so at most one grant pops it
  always_comb begin
    pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      if (out_valid[o] && out_ready[o]) pop[out_gnt[o]] = 1'b1;
    end
  end

endmodule

//--- source/noc_top.sv
// One row of four routers: chimney A, relay, memory, chimney B
// The relay router's local port is tied off, nothing ever targets node 1
// Outer edges of node 0 (west) and node 3 (east) are unconnected

`timescale 1ns/1ps

module noc_top (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // APB port A
  input  logic                           psel_a_i,
  input  logic                           penable_a_i,
  input  logic                           pwrite_a_i,
  input  logic [noc_pkg::PaddrWidth-1:0] paddr_a_i,
  input  logic [noc_pkg::DataWidth-1:0]  pwdata_a_i,
  output logic [noc_pkg::DataWidth-1:0]  prdata_a_o,
  output logic                           pready_a_o,
  output logic                           pslverr_a_o,
  // APB port B
  input  logic                           psel_b_i,
  input  logic                           penable_b_i,
  input  logic                           pwrite_b_i,
  input  logic [noc_pkg::PaddrWidth-1:0] paddr_b_i,
  input  logic [noc_pkg::DataWidth-1:0]  pwdata_b_i,
  output logic [noc_pkg::DataWidth-1:0]  prdata_b_o,
  output logic                           pready_b_o,
  output logic                           pslverr_b_o
);

  import noc_pkg::*;

  // Eastbound links, router n east out to router n+1 west in
  flit_t east_01_flit, east_12_flit, east_23_flit;
  logic  east_01_valid, east_12_valid, east_23_valid;
  logic  east_01_ready, east_12_ready, east_23_ready;
  // Westbound links, router n+1 west out to router n east in
  flit_t west_10_flit, west_21_flit, west_32_flit;
  logic  west_10_valid, west_21_valid, west_32_valid;
  logic  west_10_ready, west_21_ready, west_32_ready;
  // Local links
  flit_t a_req_flit, a_rsp_flit, b_req_flit, b_rsp_flit, m_req_flit, m_rsp_flit;
  logic  a_req_valid, a_rsp_valid, b_req_valid, b_rsp_valid, m_req_valid, m_rsp_valid;
  logic  a_req_ready, a_rsp_ready, b_req_ready, b_rsp_ready, m_req_ready, m_rsp_ready;

  ////////////////////////////////////////////////////////////////////
  // Routers
  ////////////////////////////////////////////////////////////////////

  noc_router i_router_0 (
    .clk_i, .reset_i, .node_id_i(NodeChimA),
    .west_flit_i ('0),          .west_valid_i (1'b0),          .west_ready_o (),
    .west_flit_o (),            .west_valid_o (),              .west_ready_i (1'b0),
    .east_flit_i (west_10_flit), .east_valid_i (west_10_valid), .east_ready_o (west_10_ready),
    .east_flit_o (east_01_flit), .east_valid_o (east_01_valid), .east_ready_i (east_01_ready),
    .local_flit_i(a_req_flit),  .local_valid_i(a_req_valid),   .local_ready_o(a_req_ready),
    .local_flit_o(a_rsp_flit),  .local_valid_o(a_rsp_valid),   .local_ready_i(a_rsp_ready)
  );

  // Relay node, local inject and eject are dead
  noc_router i_router_1 (
    .clk_i, .reset_i, .node_id_i(NodeRelay),
    .west_flit_i (east_01_flit), .west_valid_i (east_01_valid), .west_ready_o (east_01_ready),
    .west_flit_o (west_10_flit), .west_valid_o (west_10_valid), .west_ready_i (west_10_ready),
    .east_flit_i (west_21_flit), .east_valid_i (west_21_valid), .east_ready_o (west_21_ready),
    .east_flit_o (east_12_flit), .east_valid_o (east_12_valid), .east_ready_i (east_12_ready),
    .local_flit_i('0),          .local_valid_i(1'b0),          .local_ready_o(),
    .local_flit_o(),            .local_valid_o(),              .local_ready_i(1'b0)
  );

  noc_router i_router_2 (
    .clk_i, .reset_i, .node_id_i(NodeMem),
    .west_flit_i (east_12_flit), .west_valid_i (east_12_valid), .west_ready_o (east_12_ready),
    .west_flit_o (west_21_flit), .west_valid_o (west_21_valid), .west_ready_i (west_21_ready),
    .east_flit_i (west_32_flit), .east_valid_i (west_32_valid), .east_ready_o (west_32_ready),
    .east_flit_o (east_23_flit), .east_valid_o (east_23_valid), .east_ready_i (east_23_ready),
    .local_flit_i(m_rsp_flit),  .local_valid_i(m_rsp_valid),   .local_ready_o(m_rsp_ready),
    .local_flit_o(m_req_flit),  .local_valid_o(m_req_valid),   .local_ready_i(m_req_ready)
  );

  noc_router i_router_3 (
    .clk_i, .reset_i, .node_id_i(NodeChimB),
    .west_flit_i (east_23_flit), .west_valid_i (east_23_valid), .west_ready_o (east_23_ready),
    .west_flit_o (west_32_flit), .west_valid_o (west_32_valid), .west_ready_i (west_32_ready),
    .east_flit_i ('0),          .east_valid_i (1'b0),          .east_ready_o (),
    .east_flit_o (),            .east_valid_o (),              .east_ready_i (1'b0),
    .local_flit_i(b_req_flit),  .local_valid_i(b_req_valid),   .local_ready_o(b_req_ready),
    .local_flit_o(b_rsp_flit),  .local_valid_o(b_rsp_valid),   .local_ready_i(b_rsp_ready)
  );

  ////////////////////////////////////////////////////////////////////
  // Endpoints
  ////////////////////////////////////////////////////////////////////

  apb_chimney i_chimney_a (
    .clk_i, .reset_i, .node_id_i(NodeChimA),
    .psel_i     (psel_a_i),    .penable_i(penable_a_i), .pwrite_i (pwrite_a_i),
    .paddr_i    (paddr_a_i),   .pwdata_i (pwdata_a_i),  .prdata_o (prdata_a_o),
    .pready_o   (pready_a_o),  .pslverr_o(pslverr_a_o),
    .req_flit_o (a_req_flit),  .req_valid_o(a_req_valid), .req_ready_i(a_req_ready),
    .rsp_flit_i (a_rsp_flit),  .rsp_valid_i(a_rsp_valid), .rsp_ready_o(a_rsp_ready)
  );

  apb_chimney i_chimney_b (
    .clk_i, .reset_i, .node_id_i(NodeChimB),
    .psel_i     (psel_b_i),    .penable_i(penable_b_i), .pwrite_i (pwrite_b_i),
    .paddr_i    (paddr_b_i),   .pwdata_i (pwdata_b_i),  .prdata_o (prdata_b_o),
    .pready_o   (pready_b_o),  .pslverr_o(pslverr_b_o),
    .req_flit_o (b_req_flit),  .req_valid_o(b_req_valid), .req_ready_i(b_req_ready),
    .rsp_flit_i (b_rsp_flit),  .rsp_valid_i(b_rsp_valid), .rsp_ready_o(b_rsp_ready)
  );

  mem_endpoint i_mem (
    .clk_i, .reset_i,
    .req_flit_i (m_req_flit), .req_valid_i(m_req_valid), .req_ready_o(m_req_ready),
    .rsp_flit_o (m_rsp_flit), .rsp_valid_o(m_rsp_valid), .rsp_ready_i(m_rsp_ready)
  );

endmodule

//--- vlog.f
source/noc_pkg.sv
source/noc_router.sv
source/apb_chimney.sv
source/mem_endpoint.sv
source/noc_top.sv
dv/noc_tb.sv
